// ==== rtl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // architectural register index, r0 to r7
    localparam int arch_reg_bits = 3;
    localparam int num_arch_regs = 1 << arch_reg_bits;

    // immediate field, sign-extended by the execute stage
    localparam int imm_bits = 8;

    // r0 is never renamed and always reads zero
    localparam logic [arch_reg_bits-1:0] zero_reg = '0;

    // two-bit opcode field
    typedef enum logic [1:0] {
        // rs1 + rs2
        op_add  = 2'd0,
        // rs1 - rs2
        op_sub  = 2'd1,
        // rs1 + sext(imm)
        op_addi = 2'd2,
        // low data_width bits of rs1 * rs2
        op_mul  = 2'd3
    } opcode_t;

endpackage

`default_nettype wire

// ==== rtl/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // life cycle of one reorder buffer slot
    typedef enum logic [1:0] {
        st_empty   = 2'd0,
        // allocated, operands maybe pending
        st_waiting = 2'd1,
        // sent to execute, result not back yet
        st_issued  = 2'd2,
        // result written, waiting to reach the head
        st_done    = 2'd3
    } entry_state_t;

    // which execute pipe an opcode uses
    typedef enum logic {
        path_alu = 1'b0,
        path_mul = 1'b1
    } exec_path_t;

    // only multiplies take the long pipe
    function automatic exec_path_t path_of(input isa_pkg::opcode_t op);
        return (op == isa_pkg::op_mul) ? path_mul : path_alu;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/rename_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_stage #(
    parameter int num_pregs = 16,
    parameter int rob_depth = 8
) (
    input  wire logic                               clock,
    input  wire logic                               reset,
    input  wire logic                               inst_valid,
    input  wire isa_pkg::opcode_t                   inst_op,
    input  wire logic [isa_pkg::arch_reg_bits-1:0]  inst_rd,
    input  wire logic [isa_pkg::arch_reg_bits-1:0]  inst_rs1,
    input  wire logic [isa_pkg::arch_reg_bits-1:0]  inst_rs2,
    input  wire logic [isa_pkg::imm_bits-1:0]       inst_imm,
    input  wire logic                               rob_full,
    input  wire logic                               free_valid,
    input  wire logic [$clog2(num_pregs)-1:0]       free_tag,
    output logic                                    stall,
    output logic                                    alloc_valid,
    output isa_pkg::opcode_t                        alloc_op,
    output logic [isa_pkg::arch_reg_bits-1:0]       alloc_rd,
    output logic [$clog2(num_pregs)-1:0]            alloc_tag,
    output logic [$clog2(num_pregs)-1:0]            alloc_old_tag,
    output logic [$clog2(num_pregs)-1:0]            alloc_src1_tag,
    output logic [$clog2(num_pregs)-1:0]            alloc_src2_tag,
    output logic [isa_pkg::imm_bits-1:0]            alloc_imm
);

    localparam int tag_bits   = $clog2(num_pregs);
    // registers beyond the initial identity mapping
    localparam int free_depth = num_pregs - isa_pkg::num_arch_regs;
    localparam int ptr_bits   = (free_depth > 1) ? $clog2(free_depth) : 1;
    localparam int cnt_bits   = $clog2(free_depth + 1);

    if (free_depth < 1 || (rob_depth & (rob_depth - 1)) != 0) begin : g_param_check
        $error("rename_stage needs num_pregs above 8 and a power of two rob_depth");
    end

    // speculative map, arch reg to phys reg
    logic [tag_bits-1:0] map_table [isa_pkg::num_arch_regs];
    // circular free list
    logic [tag_bits-1:0] free_mem [free_depth];
    logic [ptr_bits-1:0] fl_head;
    logic [ptr_bits-1:0] fl_tail;
    logic [cnt_bits-1:0] fl_count;
    logic                needs_preg;
    logic                pop;

    // free list wraps at free_depth, which need not be a power of two
    function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] p);
        return (p == ptr_bits'(free_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    // r0 writers need no phys reg and never stall on the free list
    assign needs_preg  = inst_rd != isa_pkg::zero_reg;
    assign stall       = rob_full || (fl_count == '0 && needs_preg);
    assign alloc_valid = inst_valid && !stall;
    assign pop         = alloc_valid && needs_preg;

    // sources see the map before this instruction's own rename
    assign alloc_src1_tag = map_table[inst_rs1];
    assign alloc_src2_tag = map_table[inst_rs2];
    // r0 destinations carry tag 0 for both new and old
    assign alloc_tag      = needs_preg ? free_mem[fl_head] : '0;
    assign alloc_old_tag  = needs_preg ? map_table[inst_rd] : '0;
    assign alloc_op       = inst_op;
    assign alloc_rd       = inst_rd;
    assign alloc_imm      = inst_imm;

    always_ff @(posedge clock) begin
        if (reset) begin
            // ri maps to phys i
            for (int i = 0; i < isa_pkg::num_arch_regs; i++) begin
                map_table[i] <= tag_bits'(i);
            end
            // remaining phys regs start out free
            for (int i = 0; i < free_depth; i++) begin
                free_mem[i] <= tag_bits'(isa_pkg::num_arch_regs + i);
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= cnt_bits'(free_depth);
        end else begin
            if (pop) begin
                map_table[inst_rd] <= free_mem[fl_head];
                fl_head            <= next_ptr(fl_head);
            end
            // retire push may land in the same cycle as a pop
            if (free_valid) begin
                free_mem[fl_tail] <= free_tag;
                fl_tail           <= next_ptr(fl_tail);
            end
            fl_count <= fl_count + cnt_bits'(free_valid) - cnt_bits'(pop);
        end
    end

    // retire only ever returns what dispatch took, so the list never overfills
    assert property (@(posedge clock) disable iff (reset)
        free_valid |-> fl_count < cnt_bits'(free_depth));

endmodule

`default_nettype wire

// ==== rtl/phys_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module phys_regfile #(
    parameter int num_pregs  = 16,
    parameter int data_width = 32
) (
    input  wire logic                          clock,
    input  wire logic                          reset,
    input  wire logic                          alloc_valid,
    input  wire logic [$clog2(num_pregs)-1:0]  alloc_tag,
    input  wire logic [$clog2(num_pregs)-1:0]  issue_src1_tag,
    input  wire logic [$clog2(num_pregs)-1:0]  issue_src2_tag,
    input  wire logic [$clog2(num_pregs)-1:0]  retire_tag,
    input  wire logic                          wb_valid,
    input  wire logic [$clog2(num_pregs)-1:0]  wb_tag,
    input  wire logic [data_width-1:0]         wb_value,
    output logic                               src1_ready,
    output logic                               src2_ready,
    output logic [data_width-1:0]              src1_value,
    output logic [data_width-1:0]              src2_value,
    output logic [data_width-1:0]              retire_value
);

    logic [data_width-1:0] values [num_pregs];
    logic [num_pregs-1:0]  ready;

    // all three read ports are combinational
    assign src1_ready   = ready[issue_src1_tag];
    assign src2_ready   = ready[issue_src2_tag];
    assign src1_value   = values[issue_src1_tag];
    assign src2_value   = values[issue_src2_tag];
    assign retire_value = values[retire_tag];

    always_ff @(posedge clock) begin
        if (reset) begin
            // arch state starts at zero in every register
            for (int i = 0; i < num_pregs; i++) begin
                values[i] <= '0;
            end
            ready <= '1;
        end else begin
            // phys 0 stays zero and ready
            if (alloc_valid && alloc_tag != '0) begin
                ready[alloc_tag] <= 1'b0;
            end
            if (wb_valid && wb_tag != '0) begin
                values[wb_tag] <= wb_value;
                ready[wb_tag]  <= 1'b1;
            end
        end
    end

    // each renamed destination is produced exactly once after its allocation
    assert property (@(posedge clock) disable iff (reset)
        (wb_valid && wb_tag != '0) |-> !ready[wb_tag]);

endmodule

`default_nettype wire

// ==== rtl/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit #(
    parameter int data_width = 32,
    parameter int num_pregs  = 16,
    parameter int rob_depth  = 8
) (
    input  wire logic                          clock,
    input  wire logic                          reset,
    input  wire logic                          issue_valid,
    input  wire isa_pkg::opcode_t              issue_op,
    input  wire logic [$clog2(num_pregs)-1:0]  issue_tag,
    input  wire logic [$clog2(rob_depth)-1:0]  issue_rob_index,
    input  wire logic [isa_pkg::imm_bits-1:0]  issue_imm,
    input  wire logic [data_width-1:0]         src1_value,
    input  wire logic [data_width-1:0]         src2_value,
    output logic                               issue_block,
    output logic                               wb_valid,
    output logic [$clog2(num_pregs)-1:0]       wb_tag,
    output logic [data_width-1:0]              wb_value,
    output logic [$clog2(rob_depth)-1:0]       wb_rob_index
);

    localparam int tag_bits   = $clog2(num_pregs);
    localparam int index_bits = $clog2(rob_depth);

    logic                  is_mul;
    logic [data_width-1:0] imm_ext;
    logic [data_width-1:0] alu_result;
    // stage 1 payload is shared, only one op issues per cycle
    logic                  alu_valid;
    logic [tag_bits-1:0]   s1_tag;
    logic [index_bits-1:0] s1_index;
    logic [data_width-1:0] alu_value;
    logic [data_width-1:0] mul_a;
    logic [data_width-1:0] mul_b;
    // multiplier stage valids, bit 0 is stage 1
    logic [2:0]            mul_valid;
    logic [tag_bits-1:0]   m2_tag;
    logic [tag_bits-1:0]   m3_tag;
    logic [index_bits-1:0] m2_index;
    logic [index_bits-1:0] m3_index;
    logic [data_width-1:0] m2_prod;
    logic [data_width-1:0] m3_prod;

    assign is_mul  = core_pkg::path_of(issue_op) == core_pkg::path_mul;
    assign imm_ext = {{(data_width - isa_pkg::imm_bits){issue_imm[isa_pkg::imm_bits-1]}},
                      issue_imm};

    always_comb begin
        case (issue_op)
            isa_pkg::op_sub:  alu_result = src1_value - src2_value;
            isa_pkg::op_addi: alu_result = src1_value + imm_ext;
            // op_add, mul results come from the other pipe
            default:          alu_result = src1_value + src2_value;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            alu_valid <= 1'b0;
            mul_valid <= '0;
        end else begin
            alu_valid <= issue_valid && !is_mul;
            mul_valid <= {mul_valid[1:0], issue_valid && is_mul};
        end
    end

    always_ff @(posedge clock) begin
        s1_tag    <= issue_tag;
        s1_index  <= issue_rob_index;
        alu_value <= alu_result;
        mul_a     <= src1_value;
        mul_b     <= src2_value;
        // stage 2 multiplies, stage 3 holds the product for writeback
        m2_tag    <= s1_tag;
        m2_index  <= s1_index;
        m2_prod   <= mul_a * mul_b;
        m3_tag    <= m2_tag;
        m3_index  <= m2_index;
        m3_prod   <= m2_prod;
    end

    // a 1-cycle op now would land with the multiply in stage 2
    assign issue_block = mul_valid[1];

    // single writeback port
    assign wb_valid     = alu_valid || mul_valid[2];
    assign wb_tag       = mul_valid[2] ? m3_tag : s1_tag;
    assign wb_rob_index = mul_valid[2] ? m3_index : s1_index;
    assign wb_value     = mul_valid[2] ? m3_prod : alu_value;

    // the issue check in the reorder buffer keeps the pipes apart
    assert property (@(posedge clock) disable iff (reset)
        !(alu_valid && mul_valid[2]));

endmodule

`default_nettype wire

// ==== rtl/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
    parameter int rob_depth = 8,
    parameter int num_pregs = 16
) (
    input  wire logic                               clock,
    input  wire logic                               reset,
    input  wire logic                               alloc_valid,
    input  wire isa_pkg::opcode_t                   alloc_op,
    input  wire logic [isa_pkg::arch_reg_bits-1:0]  alloc_rd,
    input  wire logic [$clog2(num_pregs)-1:0]       alloc_tag,
    input  wire logic [$clog2(num_pregs)-1:0]       alloc_old_tag,
    input  wire logic [$clog2(num_pregs)-1:0]       alloc_src1_tag,
    input  wire logic [$clog2(num_pregs)-1:0]       alloc_src2_tag,
    input  wire logic [isa_pkg::imm_bits-1:0]       alloc_imm,
    input  wire logic                               src1_ready,
    input  wire logic                               src2_ready,
    input  wire logic                               issue_block,
    input  wire logic                               wb_valid,
    input  wire logic [$clog2(rob_depth)-1:0]       wb_rob_index,
    output logic                                    rob_full,
    output logic [$clog2(num_pregs)-1:0]            issue_src1_tag,
    output logic [$clog2(num_pregs)-1:0]            issue_src2_tag,
    output logic                                    issue_valid,
    output isa_pkg::opcode_t                        issue_op,
    output logic [$clog2(num_pregs)-1:0]            issue_tag,
    output logic [$clog2(rob_depth)-1:0]            issue_rob_index,
    output logic [isa_pkg::imm_bits-1:0]            issue_imm,
    output logic                                    free_valid,
    output logic [$clog2(num_pregs)-1:0]            free_tag,
    output logic                                    retire_valid,
    output logic [isa_pkg::arch_reg_bits-1:0]       retire_rd,
    output logic [$clog2(num_pregs)-1:0]            retire_tag
);

    localparam int tag_bits   = $clog2(num_pregs);
    localparam int index_bits = $clog2(rob_depth);
    localparam int cnt_bits   = index_bits + 1;

    core_pkg::entry_state_t              state [rob_depth];
    isa_pkg::opcode_t                    op_q [rob_depth];
    logic [isa_pkg::arch_reg_bits-1:0]   rd_q [rob_depth];
    logic [tag_bits-1:0]                 tag_q [rob_depth];
    logic [tag_bits-1:0]                 old_tag_q [rob_depth];
    logic [tag_bits-1:0]                 src1_q [rob_depth];
    logic [tag_bits-1:0]                 src2_q [rob_depth];
    logic [isa_pkg::imm_bits-1:0]        imm_q [rob_depth];
    // head retires, issue_ptr issues, tail allocates
    logic [index_bits-1:0]               head;
    logic [index_bits-1:0]               issue_ptr;
    logic [index_bits-1:0]               tail;
    logic [cnt_bits-1:0]                 count;
    logic                                issue_is_alu;
    logic                                retire_now;

    assign rob_full = count == cnt_bits'(rob_depth);

    // in-order issue, the entry at issue_ptr is the oldest unissued one
    assign issue_rob_index = issue_ptr;
    assign issue_src1_tag  = src1_q[issue_ptr];
    assign issue_src2_tag  = src2_q[issue_ptr];
    assign issue_op        = op_q[issue_ptr];
    assign issue_tag       = tag_q[issue_ptr];
    assign issue_imm       = imm_q[issue_ptr];
    assign issue_is_alu    = core_pkg::path_of(op_q[issue_ptr]) == core_pkg::path_alu;
    // multiplies never collide, so only 1-cycle ops honour the block
    assign issue_valid     = state[issue_ptr] == core_pkg::st_waiting
                             && src1_ready && src2_ready
                             && !(issue_is_alu && issue_block);

    // retire the head once done, r0 writers have nothing to free
    assign retire_now = state[head] == core_pkg::st_done;
    assign free_valid = retire_now && rd_q[head] != isa_pkg::zero_reg;
    assign free_tag   = old_tag_q[head];

    // the four updates always touch different slots
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rob_depth; i++) begin
                state[i] <= core_pkg::st_empty;
            end
            head         <= '0;
            issue_ptr    <= '0;
            tail         <= '0;
            count        <= '0;
            retire_valid <= 1'b0;
        end else begin
            if (alloc_valid) begin
                state[tail] <= core_pkg::st_waiting;
                tail        <= tail + 1'b1;
            end
            if (issue_valid) begin
                state[issue_ptr] <= core_pkg::st_issued;
                issue_ptr        <= issue_ptr + 1'b1;
            end
            if (wb_valid) begin
                state[wb_rob_index] <= core_pkg::st_done;
            end
            if (retire_now) begin
                state[head] <= core_pkg::st_empty;
                head        <= head + 1'b1;
            end
            count        <= count + cnt_bits'(alloc_valid) - cnt_bits'(retire_now);
            retire_valid <= retire_now;
        end
    end

    always_ff @(posedge clock) begin
        if (alloc_valid) begin
            op_q[tail]      <= alloc_op;
            rd_q[tail]      <= alloc_rd;
            tag_q[tail]     <= alloc_tag;
            old_tag_q[tail] <= alloc_old_tag;
            src1_q[tail]    <= alloc_src1_tag;
            src2_q[tail]    <= alloc_src2_tag;
            imm_q[tail]     <= alloc_imm;
        end
        // regfile reads this tag during the retire_valid cycle
        retire_rd  <= rd_q[head];
        retire_tag <= tag_q[head];
    end

    // dispatch honours the stall level from rename
    assert property (@(posedge clock) disable iff (reset) alloc_valid |-> !rob_full);

    // execute only returns results for slots it was handed
    assert property (@(posedge clock) disable iff (reset)
        wb_valid |-> state[wb_rob_index] == core_pkg::st_issued);

endmodule

`default_nettype wire

// ==== rtl/rename_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_core #(
    parameter int data_width = 32,
    parameter int num_pregs  = 16,
    parameter int rob_depth  = 8
) (
    input  wire logic                               clock,
    input  wire logic                               reset,
    input  wire logic                               inst_valid,
    input  wire isa_pkg::opcode_t                   inst_op,
    input  wire logic [isa_pkg::arch_reg_bits-1:0]  inst_rd,
    input  wire logic [isa_pkg::arch_reg_bits-1:0]  inst_rs1,
    input  wire logic [isa_pkg::arch_reg_bits-1:0]  inst_rs2,
    input  wire logic [isa_pkg::imm_bits-1:0]       inst_imm,
    output logic                                    stall,
    output logic                                    retire_valid,
    output logic [isa_pkg::arch_reg_bits-1:0]       retire_rd,
    output logic [data_width-1:0]                   retire_value
);

    localparam int tag_bits   = $clog2(num_pregs);
    localparam int index_bits = $clog2(rob_depth);

    // rename to reorder buffer and regfile
    logic                              alloc_valid;
    isa_pkg::opcode_t                  alloc_op;
    logic [isa_pkg::arch_reg_bits-1:0] alloc_rd;
    logic [tag_bits-1:0]               alloc_tag;
    logic [tag_bits-1:0]               alloc_old_tag;
    logic [tag_bits-1:0]               alloc_src1_tag;
    logic [tag_bits-1:0]               alloc_src2_tag;
    logic [isa_pkg::imm_bits-1:0]      alloc_imm;
    logic                              rob_full;
    // issue path
    logic [tag_bits-1:0]               issue_src1_tag;
    logic [tag_bits-1:0]               issue_src2_tag;
    logic                              src1_ready;
    logic                              src2_ready;
    logic [data_width-1:0]             src1_value;
    logic [data_width-1:0]             src2_value;
    logic                              issue_valid;
    isa_pkg::opcode_t                  issue_op;
    logic [tag_bits-1:0]               issue_tag;
    logic [index_bits-1:0]             issue_rob_index;
    logic [isa_pkg::imm_bits-1:0]      issue_imm;
    logic                              issue_block;
    // writeback and retire
    logic                              wb_valid;
    logic [tag_bits-1:0]               wb_tag;
    logic [data_width-1:0]             wb_value;
    logic [index_bits-1:0]             wb_rob_index;
    logic                              free_valid;
    logic [tag_bits-1:0]               free_tag;
    logic [tag_bits-1:0]               retire_tag;

    rename_stage #(
        .num_pregs (num_pregs),
        .rob_depth (rob_depth)
    ) u_rename (
        .clock, .reset, .inst_valid, .inst_op, .inst_rd, .inst_rs1, .inst_rs2, .inst_imm,
        .rob_full, .free_valid, .free_tag, .stall,
        .alloc_valid, .alloc_op, .alloc_rd, .alloc_tag, .alloc_old_tag,
        .alloc_src1_tag, .alloc_src2_tag, .alloc_imm
    );

    phys_regfile #(
        .num_pregs  (num_pregs),
        .data_width (data_width)
    ) u_regfile (
        .clock, .reset, .alloc_valid, .alloc_tag, .issue_src1_tag, .issue_src2_tag,
        .retire_tag, .wb_valid, .wb_tag, .wb_value,
        .src1_ready, .src2_ready, .src1_value, .src2_value, .retire_value
    );

    execute_unit #(
        .data_width (data_width),
        .num_pregs  (num_pregs),
        .rob_depth  (rob_depth)
    ) u_execute (
        .clock, .reset, .issue_valid, .issue_op, .issue_tag, .issue_rob_index, .issue_imm,
        .src1_value, .src2_value, .issue_block,
        .wb_valid, .wb_tag, .wb_value, .wb_rob_index
    );

    reorder_buffer #(
        .rob_depth (rob_depth),
        .num_pregs (num_pregs)
    ) u_rob (
        .clock, .reset, .alloc_valid, .alloc_op, .alloc_rd, .alloc_tag, .alloc_old_tag,
        .alloc_src1_tag, .alloc_src2_tag, .alloc_imm,
        .src1_ready, .src2_ready, .issue_block, .wb_valid, .wb_rob_index,
        .rob_full, .issue_src1_tag, .issue_src2_tag, .issue_valid, .issue_op, .issue_tag,
        .issue_rob_index, .issue_imm, .free_valid, .free_tag,
        .retire_valid, .retire_rd, .retire_tag
    );

endmodule

`default_nettype wire

// ==== sim/rename_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_core_tb;

    localparam int data_width    = 32;
    localparam int max_rows      = 64;
    localparam int random_rows   = 16;
    localparam int dispatch_wait = 200;
    localparam int drain_wait    = 500;

    logic                              clock;
    logic                              reset;
    logic                              inst_valid;
    isa_pkg::opcode_t                  inst_op;
    logic [isa_pkg::arch_reg_bits-1:0] inst_rd;
    logic [isa_pkg::arch_reg_bits-1:0] inst_rs1;
    logic [isa_pkg::arch_reg_bits-1:0] inst_rs2;
    logic [isa_pkg::imm_bits-1:0]      inst_imm;
    logic                              stall;
    logic                              retire_valid;
    logic [isa_pkg::arch_reg_bits-1:0] retire_rd;
    logic [data_width-1:0]             retire_value;

    // stimulus table, expected value per row comes from the model
    string                             row_name [max_rows];
    isa_pkg::opcode_t                  row_op [max_rows];
    logic [isa_pkg::arch_reg_bits-1:0] row_rd [max_rows];
    logic [isa_pkg::arch_reg_bits-1:0] row_rs1 [max_rows];
    logic [isa_pkg::arch_reg_bits-1:0] row_rs2 [max_rows];
    logic [isa_pkg::imm_bits-1:0]      row_imm [max_rows];
    logic [data_width-1:0]             row_expected [max_rows];
    int                                num_rows;
    // architectural state of the reference model
    logic [data_width-1:0]             model_regs [isa_pkg::num_arch_regs];
    // accepted rows waiting for their retire pulse, oldest first
    int                                pending_rows [$];
    int                                stall_cycles;
    int                                seed_value;

    rename_core #(
        .data_width (data_width),
        .num_pregs  (16),
        .rob_depth  (8)
    ) UUT (
        .clock, .reset, .inst_valid, .inst_op, .inst_rd, .inst_rs1, .inst_rs2, .inst_imm,
        .stall, .retire_valid, .retire_rd, .retire_value
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // opcode rules of the instruction set
    function automatic logic [data_width-1:0] reference_result(
        input isa_pkg::opcode_t op,
        input logic [data_width-1:0] a,
        input logic [data_width-1:0] b,
        input logic [isa_pkg::imm_bits-1:0] imm
    );
        logic [data_width-1:0] imm_ext;
        imm_ext = {{(data_width - isa_pkg::imm_bits){imm[isa_pkg::imm_bits-1]}}, imm};
        case (op)
            isa_pkg::op_add:  return a + b;
            isa_pkg::op_sub:  return a - b;
            isa_pkg::op_addi: return a + imm_ext;
            default:          return a * b;
        endcase
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_value(input string name, input logic [data_width-1:0] expected,
                               input logic [data_width-1:0] actual);
        if (expected !== actual) begin
            $display("error in %s expected 0x%0h actual 0x%0h", name, expected, actual);
            abort_run("value mismatch");
        end
    endtask

    // the model runs in program order while the table is built
    task automatic add_row(input string name, input isa_pkg::opcode_t op,
                           input int rd, input int rs1, input int rs2, input int imm);
        logic [data_width-1:0] result;
        result = reference_result(op, model_regs[rs1], model_regs[rs2], imm[7:0]);
        row_name[num_rows] = name;
        row_op[num_rows]   = op;
        row_rd[num_rows]   = rd[2:0];
        row_rs1[num_rows]  = rs1[2:0];
        row_rs2[num_rows]  = rs2[2:0];
        row_imm[num_rows]  = imm[7:0];
        // r0 writes vanish, the pulse still reports zero
        row_expected[num_rows] = (rd == 0) ? '0 : result;
        if (rd != 0) begin
            model_regs[rd] = result;
        end
        num_rows++;
    endtask

    // hold the row until a cycle with stall low, then move past the accepting edge
    task automatic apply_row(input int idx);
        int waited;
        waited     = 0;
        inst_valid = 1'b1;
        inst_op    = row_op[idx];
        inst_rd    = row_rd[idx];
        inst_rs1   = row_rs1[idx];
        inst_rs2   = row_rs2[idx];
        inst_imm   = row_imm[idx];
        @(negedge clock);
        while (stall) begin
            stall_cycles++;
            waited++;
            if (waited > dispatch_wait) begin
                abort_run($sformatf("row %0d was never accepted, stall stuck high", idx));
            end
            @(negedge clock);
        end
        pending_rows.push_back(idx);
        @(posedge clock);
        #5;
    endtask

    // retire pulses are registered, sample them mid cycle
    always @(negedge clock) begin
        int idx;
        if (!reset && retire_valid === 1'b1) begin
            if (pending_rows.size() == 0) begin
                abort_run("retire pulse seen with no instruction outstanding");
            end
            idx = pending_rows.pop_front();
            check_value($sformatf("%s row %0d rd", row_name[idx], idx),
                        data_width'(row_rd[idx]), data_width'(retire_rd));
            check_value($sformatf("%s row %0d value", row_name[idx], idx),
                        row_expected[idx], retire_value);
        end
    end

    initial begin
        int waited;
        reset          = 1'b1;
        inst_valid     = 1'b0;
        inst_op        = isa_pkg::op_add;
        inst_rd        = '0;
        inst_rs1       = '0;
        inst_rs2       = '0;
        inst_imm       = '0;
        num_rows       = 0;
        stall_cycles   = 0;
        seed_value     = $urandom(32'h670d);
        for (int i = 0; i < isa_pkg::num_arch_regs; i++) begin
            model_regs[i] = '0;
        end

        // dependent chain of simple ops, one writes its own source
        add_row("basic", isa_pkg::op_addi, 1, 0, 0, 5);
        add_row("basic", isa_pkg::op_addi, 2, 0, 0, 8'hfd);
        add_row("basic", isa_pkg::op_add, 3, 1, 2, 0);
        add_row("basic", isa_pkg::op_sub, 4, 1, 2, 0);
        add_row("basic", isa_pkg::op_addi, 1, 1, 0, 10);
        // short ops finish ahead of the multiply
        add_row("out of order", isa_pkg::op_mul, 5, 1, 4, 0);
        add_row("out of order", isa_pkg::op_addi, 6, 0, 0, 7);
        add_row("out of order", isa_pkg::op_addi, 7, 2, 0, 1);
        add_row("out of order", isa_pkg::op_add, 2, 3, 3, 0);
        // consumers of multiply results
        add_row("dependent", isa_pkg::op_mul, 3, 5, 5, 0);
        add_row("dependent", isa_pkg::op_add, 3, 3, 1, 0);
        add_row("dependent", isa_pkg::op_mul, 4, 3, 7, 0);
        add_row("dependent", isa_pkg::op_sub, 6, 4, 6, 0);
        // r0 as destination and as source
        add_row("r0", isa_pkg::op_addi, 0, 1, 0, 99);
        add_row("r0", isa_pkg::op_add, 1, 0, 0, 0);
        add_row("r0", isa_pkg::op_add, 7, 0, 2, 0);
        // slow head holds back issue while writers pile up
        add_row("exhaustion", isa_pkg::op_mul, 5, 5, 5, 0);
        add_row("exhaustion", isa_pkg::op_mul, 5, 5, 5, 0);
        for (int i = 0; i < 8; i++) begin
            add_row("exhaustion", isa_pkg::op_addi, (i % 7) + 1, 5, 0, i + 1);
        end
        for (int i = 0; i < random_rows; i++) begin
            add_row("random", isa_pkg::opcode_t'($urandom % 4), $urandom % 8,
                    $urandom % 8, $urandom % 8, $urandom % 256);
        end

        repeat (5) @(posedge clock);
        #5;
        reset = 1'b0;

        for (int i = 0; i < num_rows; i++) begin
            apply_row(i);
        end
        inst_valid = 1'b0;

        waited = 0;
        while (pending_rows.size() != 0) begin
            waited++;
            if (waited > drain_wait) begin
                abort_run("outstanding instructions never retired");
            end
            @(negedge clock);
        end
        // quiet window to catch any duplicate retirement
        repeat (10) @(negedge clock);

        if (stall_cycles == 0) begin
            abort_run("stall never went high while the writers piled up");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/rename_stage.sv
rtl/phys_regfile.sv
rtl/execute_unit.sv
rtl/reorder_buffer.sv
rtl/rename_core.sv
sim/rename_core_tb.sv
